//--- logic/jtag_dbg_defines.svh
/*
 * sizing macros for the JTAG debug register path
 *  DR_WIDTH        width of one user data register word
 *  TCK_SYNC_DEPTH  length of the TCK oversampling chain
 */

`ifndef JTAG_DBG_DEFINES_SVH
`define JTAG_DBG_DEFINES_SVH

// one debug word per ER1/ER2 scan
`define DR_WIDTH 32

// tck oversampling stages in the clk48m domain
// the rising edge is taken between the last two stages, the first two
// stages only settle the asynchronous pin
`define TCK_SYNC_DEPTH 4

`endif

//--- logic/jtag_dbg_pkg.sv
/*
 * shared types of the JTAG debug register path
 * word and counter vectors, pin and event structs,
 * delivered word struct and handoff FSM states
 */

`default_nettype none

`include "jtag_dbg_defines.svh"

package jtag_dbg_pkg;

	typedef logic [`DR_WIDTH-1:0] dr_word_t; // one debug register word
	typedef logic [7:0] overrun_cnt_t; // wraps at 255

	// raw outputs of the JTAG primitive
	typedef struct packed {
		logic tck;
		logic tdi;
		logic shift; // shift-dr state of a user register
		logic update; // update-dr state
		logic ce1; // ER1 selected
		logic ce2; // ER2 selected
	} jtag_pins_t;

	// per-channel event, one per sampled tck edge
	typedef struct packed {
		logic strobe;
		logic tdi;
		logic do_shift; // owned and shift seen at previous edge
		logic do_update; // owned and update high now
	} dr_evt_t;

	typedef struct packed {
		dr_word_t word;
		logic sel; // 0 = ER1, 1 = ER2
	} dbg_word_t;

	typedef enum logic [1:0] {IDLE, REQ, ACK_WAIT_LOW} handoff_state_t;

endpackage

`default_nettype wire

//--- logic/jtag_tck_sync.sv
/*
 * jtag_tck_sync
 * oversamples TCK in the clk48m domain and finds its rising edges,
 * tracks which user register owns the scan and the previous shift state,
 * and produces one event struct per channel for every sampled edge
 */

`timescale 1ns/10ps
`default_nettype none

`include "jtag_dbg_defines.svh"

module jtag_tck_sync (
	input  logic                    clk48m,
	input  logic                    jrstn,
	input  jtag_dbg_pkg::jtag_pins_t pins, // asynchronous to clk48m
	output jtag_dbg_pkg::dr_evt_t   evt_er1,
	output jtag_dbg_pkg::dr_evt_t   evt_er2
);

	logic [`TCK_SYNC_DEPTH-1:0] tck_q; // tck history, bit 0 is newest
	logic tck_rise; // zero-then-one at the tail of the chain
	logic own_er2; // 0 while ER1 owns the scan
	logic prev_shift; // shift pin at the previous sampled edge
	jtag_dbg_pkg::dr_evt_t evt_er1_d;
	jtag_dbg_pkg::dr_evt_t evt_er2_d;

	// build one channel's event for the current cycle
	// ownership used here is the value from before this edge
	function automatic jtag_dbg_pkg::dr_evt_t form_evt(input logic owned);
		jtag_dbg_pkg::dr_evt_t e;
		e.strobe = tck_rise;
		e.tdi = pins.tdi; // tdi is held for many clk48m cycles around the edge
		e.do_shift = tck_rise && owned && prev_shift;
		e.do_update = tck_rise && owned && pins.update;
		return e;
	endfunction

	assign tck_rise = !tck_q[`TCK_SYNC_DEPTH-1] && tck_q[`TCK_SYNC_DEPTH-2];

	always_comb begin
		evt_er1_d = form_evt(!own_er2);
		evt_er2_d = form_evt(own_er2);
	end

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_q <= '0;
			own_er2 <= 1'b0; // ER1 owns after reset
			prev_shift <= 1'b0;
			evt_er1 <= '0;
			evt_er2 <= '0;
		end else begin
			tck_q <= {tck_q[`TCK_SYNC_DEPTH-2:0], pins.tck};
			evt_er1 <= evt_er1_d; // strobe lands 3 to 4 cycles after the pin edge
			evt_er2 <= evt_er2_d;
			if (tck_rise) begin
				if (pins.ce1 || pins.ce2)
					own_er2 <= pins.ce2; // ce2 wins if both are high
				prev_shift <= pins.shift;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/jtag_dr_capture.sv
/*
 * jtag_dr_capture
 * one user data register: shifts tdi in at the MSB on each owned
 * shift event, and on an update event latches the finished word
 * and pulses done for one cycle
 */

`timescale 1ns/10ps
`default_nettype none

`include "jtag_dbg_defines.svh"

module jtag_dr_capture (
	input  logic                   clk48m,
	input  logic                   jrstn,
	input  jtag_dbg_pkg::dr_evt_t  evt,
	output jtag_dbg_pkg::dr_word_t done_word,
	output logic                   done
);

	// shift register, keeps its bits while the other channel owns the scan
	jtag_dbg_pkg::dr_word_t sr;
	logic shift_now;
	logic update_now;

	assign shift_now = evt.strobe && evt.do_shift;
	assign update_now = evt.strobe && evt.do_update;

	// control and shift state
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			sr <= '0;
			done <= 1'b0;
		end else begin
			done <= update_now; // one cycle pulse
			if (shift_now)
				sr <= {evt.tdi, sr[`DR_WIDTH-1:1]}; // lsb leaves first
		end
	end

	// finished word
	// on a combined shift and update edge the pre-shift contents are taken
	always_ff @(posedge clk48m) begin
		if (update_now)
			done_word <= sr;
	end

endmodule

`default_nettype wire

//--- logic/dbgreg_handoff.sv
/*
 * dbgreg_handoff
 * one pending slot per channel for finished words,
 * four-phase req/ack delivery to the SoC with ER1 first,
 * wrapping count of words overwritten while still pending
 */

`timescale 1ns/10ps
`default_nettype none

module dbgreg_handoff (
	input  logic                       clk48m,
	input  logic                       jrstn,
	input  jtag_dbg_pkg::dr_word_t     er1_word,
	input  logic                       er1_done,
	input  jtag_dbg_pkg::dr_word_t     er2_word,
	input  logic                       er2_done,
	output jtag_dbg_pkg::dbg_word_t    dbg,
	output logic                       dbg_req,
	input  logic                       dbg_ack,
	output jtag_dbg_pkg::overrun_cnt_t dbg_overrun
);

	jtag_dbg_pkg::handoff_state_t state;

	// index 0 is ER1, index 1 is ER2
	jtag_dbg_pkg::dr_word_t in_word [2];
	logic [1:0] in_done;
	jtag_dbg_pkg::dr_word_t slot_word [2];
	logic [1:0] slot_valid;
	logic [1:0] avail; // pending in slot or arriving this cycle
	logic [1:0] take; // channel delivered at this edge
	logic [1:0] ovr; // new word lands on a still-pending slot
	logic launch;
	jtag_dbg_pkg::dr_word_t pick_word;

	assign in_word[0] = er1_word;
	assign in_word[1] = er2_word;
	assign in_done = {er2_done, er1_done};

	assign avail = slot_valid | in_done;

	// start only from idle and only with ack already low
	assign launch = (state == jtag_dbg_pkg::IDLE) && !dbg_ack;
	assign take[0] = launch && avail[0];
	assign take[1] = launch && !avail[0] && avail[1]; // ER1 has priority

	// a slot being emptied at this edge can take the new word without loss
	assign ovr = in_done & slot_valid & ~take;

	// older slot content goes before a word arriving in the same cycle
	always_comb begin
		if (take[0])
			pick_word = slot_valid[0] ? slot_word[0] : in_word[0];
		else
			pick_word = slot_valid[1] ? slot_word[1] : in_word[1];
	end

	assign dbg_req = (state == jtag_dbg_pkg::REQ);

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			slot_valid <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (take[i])
					slot_valid[i] <= slot_valid[i] && in_done[i]; // refill behind the delivered word
				else
					slot_valid[i] <= slot_valid[i] || in_done[i];
			end
		end
	end

	// slot payload, newest word always wins
	always_ff @(posedge clk48m) begin
		for (int i = 0; i < 2; i++) begin
			if (in_done[i])
				slot_word[i] <= in_word[i];
		end
	end

	// delivered word, only loaded while req is low
	always_ff @(posedge clk48m) begin
		if (take != 2'b00) begin
			dbg.word <= pick_word;
			dbg.sel <= take[1];
		end
	end

	// four-phase handshake FSM
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			state <= jtag_dbg_pkg::IDLE;
		end else begin
			unique case (state)
				jtag_dbg_pkg::IDLE:
					if (take != 2'b00)
						state <= jtag_dbg_pkg::REQ; // req high one cycle after done
				jtag_dbg_pkg::REQ:
					if (dbg_ack)
						state <= jtag_dbg_pkg::ACK_WAIT_LOW; // drop req
				jtag_dbg_pkg::ACK_WAIT_LOW:
					if (!dbg_ack)
						state <= jtag_dbg_pkg::IDLE;
				default:
					state <= jtag_dbg_pkg::IDLE;
			endcase
		end
	end

	// both channels may overrun in one cycle
	always_ff @(posedge clk48m) begin
		if (!jrstn)
			dbg_overrun <= '0;
		else
			dbg_overrun <= dbg_overrun + jtag_dbg_pkg::overrun_cnt_t'(ovr[0])
				+ jtag_dbg_pkg::overrun_cnt_t'(ovr[1]);
	end

endmodule

`default_nettype wire

//--- logic/jtag_dbg_top.sv
/*
 * jtag_dbg_top
 * debug data register path: TCK synchronizer, ER1 and ER2
 * capture channels and the req/ack handoff to the SoC
 */

`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_top (
	input  logic                       clk48m,
	input  logic                       jrstn, // JTAG reset strobe
	input  jtag_dbg_pkg::jtag_pins_t   jtag,
	output jtag_dbg_pkg::dbg_word_t    dbg,
	output logic                       dbg_req,
	input  logic                       dbg_ack,
	output jtag_dbg_pkg::overrun_cnt_t dbg_overrun
);

	jtag_dbg_pkg::dr_evt_t evt_er1;
	jtag_dbg_pkg::dr_evt_t evt_er2;
	jtag_dbg_pkg::dr_word_t er1_word;
	jtag_dbg_pkg::dr_word_t er2_word;
	logic er1_done;
	logic er2_done;

	// pin sampling and per-channel events
	jtag_tck_sync tck_sync (
		.clk48m  (clk48m),
		.jrstn   (jrstn),
		.pins    (jtag),
		.evt_er1 (evt_er1),
		.evt_er2 (evt_er2)
	);

	jtag_dr_capture er1_capture ( // user instruction ER1
		.clk48m    (clk48m),
		.jrstn     (jrstn),
		.evt       (evt_er1),
		.done_word (er1_word),
		.done      (er1_done)
	);

	jtag_dr_capture er2_capture ( // user instruction ER2
		.clk48m    (clk48m),
		.jrstn     (jrstn),
		.evt       (evt_er2),
		.done_word (er2_word),
		.done      (er2_done)
	);

	// merge both channels onto the SoC handshake
	dbgreg_handoff handoff (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.er1_word    (er1_word),
		.er1_done    (er1_done),
		.er2_word    (er2_word),
		.er2_done    (er2_done),
		.dbg         (dbg),
		.dbg_req     (dbg_req),
		.dbg_ack     (dbg_ack),
		.dbg_overrun (dbg_overrun)
	);

endmodule

`default_nettype wire

//--- test/jtag_dbg_checker.sv
/*
 * jtag_dbg_checker
 * watches the DUT req/ack handoff, compares each delivered word
 * with the expected queue, prints one line per test, keeps counts
 */

`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_checker (
	input logic                       clk48m,
	input logic                       jrstn,
	input jtag_dbg_pkg::dbg_word_t    dbg,
	input logic                       dbg_req,
	input jtag_dbg_pkg::overrun_cnt_t dbg_overrun
);

	jtag_dbg_pkg::dbg_word_t exp_q [$]; // in delivery order
	int test_cnt = 0;
	int chk_cnt = 0;
	int err_cnt = 0;
	int err_base = 0; // errors before the running test
	logic req_q = 1'b0;

	function automatic void push_expected(input jtag_dbg_pkg::dbg_word_t w);
		exp_q.push_back(w);
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic void compare_word();
		jtag_dbg_pkg::dbg_word_t e;
		if (exp_q.size() == 0) begin
			err_cnt++;
			$display("time %0t: word %h delivered with no scan expecting it", $time, dbg.word);
		end else begin
			e = exp_q.pop_front();
			chk_cnt++;
			if (dbg.word !== e.word) begin
				err_cnt++;
				$display("Fail at %0t: dbg.word expected %h got %h", $time, e.word, dbg.word);
			end
			if (dbg.sel !== e.sel) begin
				err_cnt++;
				$display("Fail at %0t: dbg.sel expected %b got %b", $time, e.sel, dbg.sel);
			end
		end
	endfunction

	// mid-cycle sampling, outputs are settled at the falling edge
	always @(negedge clk48m) begin
		if (!jrstn) begin
			req_q <= 1'b0;
		end else begin
			req_q <= dbg_req;
			if (dbg_req && !req_q)
				compare_word(); // new word on the bus
		end
	end

	// end of a test: bus idle, overrun count, nothing left over
	function automatic void test_result(input string name,
		input jtag_dbg_pkg::overrun_cnt_t exp_ovr, input int tb_errs);
		int errs;
		chk_cnt += 2;
		if (dbg_req !== 1'b0) begin
			err_cnt++;
			$display("Fail at %0t: dbg_req expected 0 got %b", $time, dbg_req);
		end
		if (dbg_overrun !== exp_ovr) begin
			err_cnt++;
			$display("Fail at %0t: dbg_overrun expected %0d got %0d", $time, exp_ovr, dbg_overrun);
		end
		if (exp_q.size() != 0) begin
			err_cnt++;
			$display("%0d expected words were never delivered", exp_q.size());
			exp_q.delete();
		end
		errs = err_cnt + tb_errs - err_base;
		test_cnt++;
		if (errs == 0)
			$display("test %0d %s: ok", test_cnt, name);
		else
			$display("test %0d %s: %0d errors", test_cnt, name, errs);
		err_base = err_cnt + tb_errs;
	endfunction

endmodule

`default_nettype wire

//--- test/jtag_dbg_sva.sv
/*
 * jtag_dbg_sva
 * req/ack protocol and reset assertions on dbgreg_handoff, attached by bind
 */

`timescale 1ns/10ps
`default_nettype none

module jtag_dbg_sva (
	input logic                    clk48m,
	input logic                    jrstn,
	input jtag_dbg_pkg::dbg_word_t dbg,
	input logic                    dbg_req,
	input logic                    dbg_ack
);

	int fail_cnt = 0; // assertion failures so far

	// synchronous reset clears the FSM at the edge
	req_low_in_reset: assert property (@(posedge clk48m) !jrstn |=> !dbg_req)
		else begin
			$error("dbg_req high during reset");
			fail_cnt++;
		end

	req_falls_after_ack: assert property (@(posedge clk48m) disable iff (!jrstn)
		$fell(dbg_req) |-> $past(dbg_ack))
		else begin
			$error("dbg_req dropped without ack");
			fail_cnt++;
		end

	dbg_stable_in_req: assert property (@(posedge clk48m) disable iff (!jrstn)
		(dbg_req && $past(dbg_req)) |-> $stable(dbg))
		else begin
			$error("dbg changed while dbg_req high");
			fail_cnt++;
		end

	// a new request waits for ack low
	no_rise_with_ack: assert property (@(posedge clk48m) disable iff (!jrstn)
		$rose(dbg_req) |-> !$past(dbg_ack))
		else begin
			$error("dbg_req rose while ack high");
			fail_cnt++;
		end

endmodule

bind dbgreg_handoff jtag_dbg_sva handoff_sva (
	.clk48m  (clk48m),
	.jrstn   (jrstn),
	.dbg     (dbg),
	.dbg_req (dbg_req),
	.dbg_ack (dbg_ack)
);

`default_nettype wire

//--- test/tb_jtag_dbg.sv
/*
 * tb_jtag_dbg
 * clock and reset, bit-banged JTAG pins, ack responder,
 * reference model of shifting, ownership and the pending slots
 */

`timescale 1ns/10ps
`default_nettype none

`include "jtag_dbg_defines.svh"

module tb_jtag_dbg;

	logic clk48m = 1'b0;
	logic jrstn;
	jtag_dbg_pkg::jtag_pins_t jtag;
	jtag_dbg_pkg::dbg_word_t dbg;
	logic dbg_req;
	logic dbg_ack;
	jtag_dbg_pkg::overrun_cnt_t dbg_overrun;

	int seed;
	int ack_delay; // cycles from req to ack
	logic hold_ack; // responder stays silent while set
	int tb_err_cnt;

	// reference model state
	jtag_dbg_pkg::jtag_pins_t edge_q [$]; // pins at every tck rise
	int ref_pos; // next edge to replay
	logic ref_own_er2;
	logic ref_prev_shift;
	jtag_dbg_pkg::dr_word_t ref_sr [2];
	logic ref_busy; // a word sits on dbg waiting for ack
	logic [1:0] ref_slot_valid;
	jtag_dbg_pkg::dbg_word_t ref_slot [2];
	jtag_dbg_pkg::overrun_cnt_t ref_overrun;

	always #4 clk48m = ~clk48m; // 8 ns period

	jtag_dbg_top dut (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.jtag        (jtag),
		.dbg         (dbg),
		.dbg_req     (dbg_req),
		.dbg_ack     (dbg_ack),
		.dbg_overrun (dbg_overrun)
	);

	jtag_dbg_checker chk (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.dbg         (dbg),
		.dbg_req     (dbg_req),
		.dbg_overrun (dbg_overrun)
	);

	function automatic logic rand_bit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	// errors found outside the word checker
	function automatic int side_errors();
		return tb_err_cnt + dut.handoff.handoff_sva.fail_cnt;
	endfunction

	// one word waits on dbg plus one pending slot per channel
	function automatic void queue_expected(input jtag_dbg_pkg::dbg_word_t w, input int ch);
		if (!hold_ack) begin
			chk.push_expected(w);
		end else if (!ref_busy) begin
			chk.push_expected(w); // goes straight to dbg and waits there
			ref_busy = 1'b1;
		end else begin
			if (ref_slot_valid[ch])
				ref_overrun++; // older pending word is lost
			ref_slot_valid[ch] = 1'b1;
			ref_slot[ch] = w;
		end
	endfunction

	// replay the recorded edges not seen yet
	function automatic void model_edges();
		jtag_dbg_pkg::jtag_pins_t p;
		jtag_dbg_pkg::dbg_word_t w;
		int ch;
		while (ref_pos < edge_q.size()) begin
			p = edge_q[ref_pos];
			ref_pos++;
			ch = ref_own_er2 ? 1 : 0; // owner from before this edge
			if (p.update) begin
				w.word = ref_sr[ch]; // contents before any shift on this edge
				w.sel = ref_own_er2;
				queue_expected(w, ch);
			end
			if (ref_prev_shift)
				ref_sr[ch] = {p.tdi, ref_sr[ch][`DR_WIDTH-1:1]};
			if (p.ce1 || p.ce2)
				ref_own_er2 = p.ce2;
			ref_prev_shift = p.shift;
		end
	endfunction

	// pending slots drain with ER1 first once ack returns
	function automatic void release_ack();
		for (int ch = 0; ch < 2; ch++) begin
			if (ref_slot_valid[ch])
				chk.push_expected(ref_slot[ch]);
		end
		ref_slot_valid = 2'b00;
		ref_busy = 1'b0;
		hold_ack = 1'b0;
	endfunction

	// one tck period of 16 clocks with pins changing while tck is low
	task automatic tck_cycle(input logic tdi, input logic shift, input logic update,
		input logic [1:0] ce);
		jtag_dbg_pkg::jtag_pins_t p;
		p.tck = 1'b0;
		p.tdi = tdi;
		p.shift = shift;
		p.update = update;
		p.ce1 = ce[0];
		p.ce2 = ce[1];
		jtag = p;
		edge_q.push_back(p); // the coming rise samples these pins
		model_edges();
		repeat (8) @(posedge clk48m);
		#1 jtag.tck = 1'b1;
		repeat (8) @(posedge clk48m);
		#1;
	endtask

	// select, capture, nbits shifts, optional update, idle
	task automatic dr_scan(input logic er2, input int nbits, input logic upd);
		logic [1:0] ce;
		ce = er2 ? 2'b10 : 2'b01;
		tck_cycle(1'b0, 1'b0, 1'b0, ce);
		tck_cycle(1'b0, nbits > 0, 1'b0, ce); // shifting starts at the next edge
		for (int i = 0; i < nbits; i++)
			tck_cycle(rand_bit(), i < nbits - 1, 1'b0, ce);
		if (upd)
			tck_cycle(1'b0, 1'b0, 1'b1, ce);
		tck_cycle(1'b0, 1'b0, 1'b0, 2'b00);
	endtask

	task automatic wait_delivered(input string what);
		int n;
		n = 0;
		while ((chk.pending() != 0 || dbg_req || dbg_ack) && n < 3000) begin
			@(posedge clk48m);
			#1;
			n++;
		end
		if (n >= 3000) begin
			$display("timeout at %0t: %s not delivered and acknowledged", $time, what);
			tb_err_cnt++;
		end
	endtask

	// four-phase consumer
	always begin : ack_responder
		int n;
		@(posedge clk48m);
		#1;
		if (dbg_req === 1'b1 && !hold_ack) begin
			repeat (ack_delay) @(posedge clk48m);
			#1 dbg_ack = 1'b1;
			n = 0;
			while (dbg_req && n < 100) begin
				@(posedge clk48m);
				#1;
				n++;
			end
			if (dbg_req) begin
				$display("timeout at %0t: dbg_req stayed high after ack", $time);
				tb_err_cnt++;
			end
			repeat (ack_delay) @(posedge clk48m); // ack stays high after req falls
			#1 dbg_ack = 1'b0;
		end
	end

	initial begin
		seed = 32'h1daf_cd2f;
		jtag = '0;
		dbg_ack = 1'b0;
		jrstn = 1'b0;
		hold_ack = 1'b0;
		ack_delay = 2;
		tb_err_cnt = 0;
		ref_pos = 0;
		ref_own_er2 = 1'b0; // ER1 owns after reset
		ref_prev_shift = 1'b0;
		ref_sr[0] = '0;
		ref_sr[1] = '0;
		ref_busy = 1'b0;
		ref_slot_valid = 2'b00;
		ref_overrun = '0;
		repeat (3) @(posedge clk48m);
		#1 jrstn = 1'b1;

		// no word may come out of idle pins
		repeat (4) tck_cycle(1'b0, 1'b0, 1'b0, 2'b00);
		chk.test_result("reset state", ref_overrun, side_errors());

		dr_scan(1'b0, 32, 1'b1);
		wait_delivered("ER1 word");
		chk.test_result("er1 full scan", ref_overrun, side_errors());

		dr_scan(1'b1, 32, 1'b1);
		dr_scan(1'b1, 10, 1'b0); // partial scan without update
		dr_scan(1'b0, 12, 1'b1); // short ER1 scan keeps bits of the earlier ER1 word
		dr_scan(1'b1, 5, 1'b1); // short scan keeps older ER2 bits
		wait_delivered("ER2 and ER1 words");
		chk.test_result("er2 and retained contents", ref_overrun, side_errors());

		hold_ack = 1'b1;
		dr_scan(1'b0, 32, 1'b1); // occupies dbg
		dr_scan(1'b1, 32, 1'b1);
		dr_scan(1'b0, 32, 1'b1);
		release_ack();
		wait_delivered("back-pressured words");
		chk.test_result("back-pressure order", ref_overrun, side_errors());

		hold_ack = 1'b1;
		dr_scan(1'b1, 8, 1'b1);
		dr_scan(1'b0, 32, 1'b1);
		dr_scan(1'b0, 32, 1'b1); // overwrites the pending ER1 slot
		release_ack();
		wait_delivered("overrun words");
		chk.test_result("er1 overrun", ref_overrun, side_errors());

		$display("tests %0d, checks %0d, errors %0d", chk.test_cnt, chk.chk_cnt,
			chk.err_cnt + side_errors());
		if (chk.err_cnt + side_errors() == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/jtag_dbg_pkg.sv
logic/jtag_tck_sync.sv
logic/jtag_dr_capture.sv
logic/dbgreg_handoff.sv
logic/jtag_dbg_top.sv
test/jtag_dbg_checker.sv
test/jtag_dbg_sva.sv
test/tb_jtag_dbg.sv

//--- Makefile
# Verilator build of the JTAG debug register testbench

SIM = obj_dir/Vtb_jtag_dbg

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): all.f logic/*.sv logic/*.svh test/*.sv
	verilator --binary --timing --assert -f all.f --top-module tb_jtag_dbg -Mdir obj_dir

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
